// ==== files.f ====
+incdir+include
hdl/filt_cfg_pkg.sv
hdl/filt_cfg_regs.sv
hdl/filt_job_ctrl.sv
hdl/filt_cfg_top.sv
test/tb_clk_gen.sv
test/tb_filt_cfg.sv

// ==== hdl/filt_cfg_pkg.sv ====
/*
 * Types shared by the filter configuration block.
 * Widths follow the settings header.
 */
`include "filt_cfg_settings.svh"

package filt_cfg_pkg;

    typedef logic [31:0] cfg_word_t;    // Host bus word
    typedef logic [4:0]  cfg_addr_t;    // Register word index

    typedef logic [`FILT_L2_AWIDTH-1:0]  l2_addr_t;
    typedef logic [`FILT_TRANS_SIZE-1:0] trans_len_t;

    typedef logic [1:0]  datasize_t;    // Element size code
    typedef logic [1:0]  xfer_mode_t;
    typedef logic [3:0]  au_mode_t;     // Arithmetic op
    typedef logic [4:0]  au_shift_t;
    typedef logic [2:0]  filt_mode_t;

    // Job sequencing
    typedef enum logic [1:0] {
        JOB_IDLE,
        JOB_SAMPLE,
        JOB_BUSY
    } job_state_e;

endpackage

// ==== hdl/filt_cfg_regs.sv ====
/*
 * Staging registers of the filter configuration block.
 * Writes land on the clock edge, reads are combinational; no wait states.
 * The command register is write-only and reads as zero.
 */
`timescale 1ns/1ps
`include "filt_cfg_settings.svh"

module filt_cfg_regs (
    input  logic                                clk_i,
    input  logic                                rstn_i,

    input  filt_cfg_pkg::cfg_word_t             cfg_data_i,
    input  filt_cfg_pkg::cfg_addr_t             cfg_addr_i,
    input  logic                                cfg_valid_i,
    input  logic                                cfg_rwn_i,
    output filt_cfg_pkg::cfg_word_t             cfg_data_o,

    output logic                                cmd_start_o,

    output filt_cfg_pkg::l2_addr_t   [1:0]      tx_start_addr_o,
    output filt_cfg_pkg::datasize_t  [1:0]      tx_datasize_o,
    output filt_cfg_pkg::xfer_mode_t [1:0]      tx_mode_o,
    output filt_cfg_pkg::trans_len_t [1:0]      tx_len_o,

    output filt_cfg_pkg::l2_addr_t              rx_start_addr_o,
    output filt_cfg_pkg::datasize_t             rx_datasize_o,
    output filt_cfg_pkg::xfer_mode_t            rx_mode_o,
    output filt_cfg_pkg::trans_len_t            rx_len_o,

    output logic                                au_use_signed_o,
    output logic                                au_bypass_o,
    output filt_cfg_pkg::au_mode_t              au_mode_o,
    output filt_cfg_pkg::au_shift_t             au_shift_o,

    output filt_cfg_pkg::cfg_word_t             bincu_threshold_o,
    output filt_cfg_pkg::filt_mode_t            filter_mode_o
);

    logic wr_en;
    logic rd_en;

    assign wr_en = cfg_valid_i & ~cfg_rwn_i;
    assign rd_en = cfg_valid_i &  cfg_rwn_i;

    //////////////////////////////////////////////////
    // Write decode
    //////////////////////////////////////////////////
    always_ff @(posedge clk_i, negedge rstn_i)
    begin
        if (~rstn_i)
        begin
            cmd_start_o       <= 1'b0;
            tx_start_addr_o   <= '0;
            tx_datasize_o     <= '0;
            tx_mode_o         <= '0;
            tx_len_o          <= '0;
            rx_start_addr_o   <= '0;
            rx_datasize_o     <= '0;
            rx_mode_o         <= '0;
            rx_len_o          <= '0;
            au_use_signed_o   <= 1'b0;
            au_bypass_o       <= 1'b0;
            au_mode_o         <= '0;
            au_shift_o        <= '0;
            bincu_threshold_o <= '0;
            filter_mode_o     <= '0;
        end
        else
        begin
            // One-cycle strobe, never held
            cmd_start_o <= wr_en && (cfg_addr_i == `FILT_REG_FILT_CMD) &&
                           cfg_data_i[`FILT_CMD_START];

            if (wr_en)
            begin
                case (cfg_addr_i)
                    `FILT_REG_TX0_ADDR: tx_start_addr_o[0] <= cfg_data_i[`FILT_ADDR_BITS];
                    `FILT_REG_TX0_CFG:
                    begin
                        tx_datasize_o[0] <= cfg_data_i[`FILT_CH_DSIZE];
                        tx_mode_o[0]     <= cfg_data_i[`FILT_CH_MODE];
                    end
                    `FILT_REG_TX0_LEN:  tx_len_o[0] <= cfg_data_i[`FILT_LEN_BITS];
                    `FILT_REG_TX1_ADDR: tx_start_addr_o[1] <= cfg_data_i[`FILT_ADDR_BITS];
                    `FILT_REG_TX1_CFG:
                    begin
                        tx_datasize_o[1] <= cfg_data_i[`FILT_CH_DSIZE];
                        tx_mode_o[1]     <= cfg_data_i[`FILT_CH_MODE];
                    end
                    `FILT_REG_TX1_LEN:  tx_len_o[1] <= cfg_data_i[`FILT_LEN_BITS];
                    `FILT_REG_RX_ADDR:  rx_start_addr_o <= cfg_data_i[`FILT_ADDR_BITS];
                    `FILT_REG_RX_CFG:
                    begin
                        rx_datasize_o <= cfg_data_i[`FILT_CH_DSIZE];
                        rx_mode_o     <= cfg_data_i[`FILT_CH_MODE];
                    end
                    `FILT_REG_RX_LEN:   rx_len_o <= cfg_data_i[`FILT_LEN_BITS];
                    `FILT_REG_AU_CFG:
                    begin
                        au_use_signed_o <= cfg_data_i[`FILT_AU_SIGNED];
                        au_bypass_o     <= cfg_data_i[`FILT_AU_BYPASS];
                        au_mode_o       <= cfg_data_i[`FILT_AU_MODE];
                        au_shift_o      <= cfg_data_i[`FILT_AU_SHIFT];
                    end
                    `FILT_REG_BINCU_TH:  bincu_threshold_o <= cfg_data_i;
                    `FILT_REG_FILT_MODE: filter_mode_o <= cfg_data_i[`FILT_MODE_BITS];
                    default: ;  // Unmapped, and CMD which only strobes
                endcase
            end
        end
    end

    //////////////////////////////////////////////////
    // Readback
    //////////////////////////////////////////////////
    always_comb
    begin
        cfg_data_o = '0;
        if (rd_en)
        begin
            case (cfg_addr_i)
                `FILT_REG_TX0_ADDR: cfg_data_o[`FILT_ADDR_BITS] = tx_start_addr_o[0];
                `FILT_REG_TX0_CFG:
                begin
                    cfg_data_o[`FILT_CH_DSIZE] = tx_datasize_o[0];
                    cfg_data_o[`FILT_CH_MODE]  = tx_mode_o[0];
                end
                `FILT_REG_TX0_LEN:  cfg_data_o[`FILT_LEN_BITS] = tx_len_o[0];
                `FILT_REG_TX1_ADDR: cfg_data_o[`FILT_ADDR_BITS] = tx_start_addr_o[1];
                `FILT_REG_TX1_CFG:
                begin
                    cfg_data_o[`FILT_CH_DSIZE] = tx_datasize_o[1];
                    cfg_data_o[`FILT_CH_MODE]  = tx_mode_o[1];
                end
                `FILT_REG_TX1_LEN:  cfg_data_o[`FILT_LEN_BITS] = tx_len_o[1];
                `FILT_REG_RX_ADDR:  cfg_data_o[`FILT_ADDR_BITS] = rx_start_addr_o;
                `FILT_REG_RX_CFG:
                begin
                    cfg_data_o[`FILT_CH_DSIZE] = rx_datasize_o;
                    cfg_data_o[`FILT_CH_MODE]  = rx_mode_o;
                end
                `FILT_REG_RX_LEN:   cfg_data_o[`FILT_LEN_BITS] = rx_len_o;
                `FILT_REG_AU_CFG:
                begin
                    cfg_data_o[`FILT_AU_SIGNED] = au_use_signed_o;
                    cfg_data_o[`FILT_AU_BYPASS] = au_bypass_o;
                    cfg_data_o[`FILT_AU_MODE]   = au_mode_o;
                    cfg_data_o[`FILT_AU_SHIFT]  = au_shift_o;
                end
                `FILT_REG_BINCU_TH:  cfg_data_o = bincu_threshold_o;
                `FILT_REG_FILT_MODE: cfg_data_o[`FILT_MODE_BITS] = filter_mode_o;
                default:             cfg_data_o = '0;
            endcase
        end
    end

    // Host must present a clean index with every access
    a_addr_known: assert property (@(posedge clk_i) disable iff (!rstn_i)
        cfg_valid_i |-> !$isunknown(cfg_addr_i));

endmodule

// ==== hdl/filt_cfg_top.sv ====
/*
 * Filter configuration block: host staging registers feeding the job control.
 * filter_start_o pulses two cycles after the start command write.
 */
`timescale 1ns/1ps
`include "filt_cfg_settings.svh"

module filt_cfg_top (
    input  logic                                clk_i,
    input  logic                                rstn_i,

    input  filt_cfg_pkg::cfg_word_t             cfg_data_i,
    input  filt_cfg_pkg::cfg_addr_t             cfg_addr_i,
    input  logic                                cfg_valid_i,
    input  logic                                cfg_rwn_i,
    output filt_cfg_pkg::cfg_word_t             cfg_data_o,

    input  logic                                filter_done_i,
    output logic                                filter_start_o,

    output filt_cfg_pkg::l2_addr_t   [1:0]      tx_start_addr_o,
    output filt_cfg_pkg::datasize_t  [1:0]      tx_datasize_o,
    output filt_cfg_pkg::xfer_mode_t [1:0]      tx_mode_o,
    output filt_cfg_pkg::trans_len_t [1:0]      tx_len_o,
    output filt_cfg_pkg::l2_addr_t              rx_start_addr_o,
    output filt_cfg_pkg::datasize_t             rx_datasize_o,
    output filt_cfg_pkg::xfer_mode_t            rx_mode_o,
    output filt_cfg_pkg::trans_len_t            rx_len_o,
    output logic                                au_use_signed_o,
    output logic                                au_bypass_o,
    output filt_cfg_pkg::au_mode_t              au_mode_o,
    output filt_cfg_pkg::au_shift_t             au_shift_o,
    output filt_cfg_pkg::cfg_word_t             bincu_threshold_o,
    output filt_cfg_pkg::filt_mode_t            filter_mode_o
);

    import filt_cfg_pkg::*;

    // Staging side
    logic             cmd_start;
    l2_addr_t   [1:0] stg_tx_start_addr;
    datasize_t  [1:0] stg_tx_datasize;
    xfer_mode_t [1:0] stg_tx_mode;
    trans_len_t [1:0] stg_tx_len;
    l2_addr_t         stg_rx_start_addr;
    datasize_t        stg_rx_datasize;
    xfer_mode_t       stg_rx_mode;
    trans_len_t       stg_rx_len;
    logic             stg_au_use_signed;
    logic             stg_au_bypass;
    au_mode_t         stg_au_mode;
    au_shift_t        stg_au_shift;
    cfg_word_t        stg_bincu_threshold;
    filt_mode_t       stg_filter_mode;

    filt_cfg_regs regs0 (
        .clk_i             (clk_i),
        .rstn_i            (rstn_i),
        .cfg_data_i        (cfg_data_i),
        .cfg_addr_i        (cfg_addr_i),
        .cfg_valid_i       (cfg_valid_i),
        .cfg_rwn_i         (cfg_rwn_i),
        .cfg_data_o        (cfg_data_o),
        .cmd_start_o       (cmd_start),
        .tx_start_addr_o   (stg_tx_start_addr),
        .tx_datasize_o     (stg_tx_datasize),
        .tx_mode_o         (stg_tx_mode),
        .tx_len_o          (stg_tx_len),
        .rx_start_addr_o   (stg_rx_start_addr),
        .rx_datasize_o     (stg_rx_datasize),
        .rx_mode_o         (stg_rx_mode),
        .rx_len_o          (stg_rx_len),
        .au_use_signed_o   (stg_au_use_signed),
        .au_bypass_o       (stg_au_bypass),
        .au_mode_o         (stg_au_mode),
        .au_shift_o        (stg_au_shift),
        .bincu_threshold_o (stg_bincu_threshold),
        .filter_mode_o     (stg_filter_mode)
    );

    filt_job_ctrl job0 (
        .clk_i             (clk_i),
        .rstn_i            (rstn_i),
        .cmd_start_i       (cmd_start),
        .filter_done_i     (filter_done_i),
        .filter_start_o    (filter_start_o),
        .tx_start_addr_i   (stg_tx_start_addr),
        .tx_datasize_i     (stg_tx_datasize),
        .tx_mode_i         (stg_tx_mode),
        .tx_len_i          (stg_tx_len),
        .rx_start_addr_i   (stg_rx_start_addr),
        .rx_datasize_i     (stg_rx_datasize),
        .rx_mode_i         (stg_rx_mode),
        .rx_len_i          (stg_rx_len),
        .au_use_signed_i   (stg_au_use_signed),
        .au_bypass_i       (stg_au_bypass),
        .au_mode_i         (stg_au_mode),
        .au_shift_i        (stg_au_shift),
        .bincu_threshold_i (stg_bincu_threshold),
        .filter_mode_i     (stg_filter_mode),
        .tx_start_addr_o   (tx_start_addr_o),
        .tx_datasize_o     (tx_datasize_o),
        .tx_mode_o         (tx_mode_o),
        .tx_len_o          (tx_len_o),
        .rx_start_addr_o   (rx_start_addr_o),
        .rx_datasize_o     (rx_datasize_o),
        .rx_mode_o         (rx_mode_o),
        .rx_len_o          (rx_len_o),
        .au_use_signed_o   (au_use_signed_o),
        .au_bypass_o       (au_bypass_o),
        .au_mode_o         (au_mode_o),
        .au_shift_o        (au_shift_o),
        .bincu_threshold_o (bincu_threshold_o),
        .filter_mode_o     (filter_mode_o)
    );

endmodule

// ==== hdl/filt_job_ctrl.sv ====
/*
 * Job sequencing and committed configuration bank.
 * A start is acted on one cycle after the command strobe; one start can wait as pending.
 * The committed bank is stable for the whole of a job.
 */
`timescale 1ns/1ps

module filt_job_ctrl (
    input  logic                                clk_i,
    input  logic                                rstn_i,

    input  logic                                cmd_start_i,
    input  logic                                filter_done_i,
    output logic                                filter_start_o,

    input  filt_cfg_pkg::l2_addr_t   [1:0]      tx_start_addr_i,
    input  filt_cfg_pkg::datasize_t  [1:0]      tx_datasize_i,
    input  filt_cfg_pkg::xfer_mode_t [1:0]      tx_mode_i,
    input  filt_cfg_pkg::trans_len_t [1:0]      tx_len_i,
    input  filt_cfg_pkg::l2_addr_t              rx_start_addr_i,
    input  filt_cfg_pkg::datasize_t             rx_datasize_i,
    input  filt_cfg_pkg::xfer_mode_t            rx_mode_i,
    input  filt_cfg_pkg::trans_len_t            rx_len_i,
    input  logic                                au_use_signed_i,
    input  logic                                au_bypass_i,
    input  filt_cfg_pkg::au_mode_t              au_mode_i,
    input  filt_cfg_pkg::au_shift_t             au_shift_i,
    input  filt_cfg_pkg::cfg_word_t             bincu_threshold_i,
    input  filt_cfg_pkg::filt_mode_t            filter_mode_i,

    output filt_cfg_pkg::l2_addr_t   [1:0]      tx_start_addr_o,
    output filt_cfg_pkg::datasize_t  [1:0]      tx_datasize_o,
    output filt_cfg_pkg::xfer_mode_t [1:0]      tx_mode_o,
    output filt_cfg_pkg::trans_len_t [1:0]      tx_len_o,
    output filt_cfg_pkg::l2_addr_t              rx_start_addr_o,
    output filt_cfg_pkg::datasize_t             rx_datasize_o,
    output filt_cfg_pkg::xfer_mode_t            rx_mode_o,
    output filt_cfg_pkg::trans_len_t            rx_len_o,
    output logic                                au_use_signed_o,
    output logic                                au_bypass_o,
    output filt_cfg_pkg::au_mode_t              au_mode_o,
    output filt_cfg_pkg::au_shift_t             au_shift_o,
    output filt_cfg_pkg::cfg_word_t             bincu_threshold_o,
    output filt_cfg_pkg::filt_mode_t            filter_mode_o
);

    import filt_cfg_pkg::*;

    job_state_e state_q;
    job_state_e state_d;
    logic       start_q;    // Start request, one cycle after the strobe
    logic       pending_q;
    logic       commit;
    logic       set_pending;

    //////////////////////////////////////////////////
    // Start sequencing
    //////////////////////////////////////////////////
    always_comb
    begin
        state_d     = state_q;
        commit      = 1'b0;
        set_pending = 1'b0;
        case (state_q)
            JOB_IDLE:
            begin
                if (start_q)
                begin
                    commit  = 1'b1;
                    state_d = JOB_SAMPLE;
                end
            end
            JOB_SAMPLE:
            begin
                set_pending = start_q;
                state_d     = JOB_BUSY;
            end
            JOB_BUSY:
            begin
                if (filter_done_i && (start_q || pending_q))
                begin
                    commit  = 1'b1;     // Queued start runs right away
                    state_d = JOB_SAMPLE;
                end
                else if (filter_done_i)
                    state_d = JOB_IDLE;
                else
                    set_pending = start_q;
            end
            default: state_d = JOB_IDLE;
        endcase
    end

    assign filter_start_o = (state_q == JOB_SAMPLE);

    always_ff @(posedge clk_i, negedge rstn_i)
    begin
        if (~rstn_i)
        begin
            state_q   <= JOB_IDLE;
            start_q   <= 1'b0;
            pending_q <= 1'b0;
        end
        else
        begin
            state_q <= state_d;
            start_q <= cmd_start_i;
            if (commit)
                pending_q <= 1'b0;  // Merged starts all served by this commit
            else if (set_pending)
                pending_q <= 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // Committed bank
    //////////////////////////////////////////////////
    always_ff @(posedge clk_i, negedge rstn_i)
    begin
        if (~rstn_i)
        begin
            tx_start_addr_o   <= '0;
            tx_datasize_o     <= '0;
            tx_mode_o         <= '0;
            tx_len_o          <= '0;
            rx_start_addr_o   <= '0;
            rx_datasize_o     <= '0;
            rx_mode_o         <= '0;
            rx_len_o          <= '0;
            au_use_signed_o   <= 1'b0;
            au_bypass_o       <= 1'b0;
            au_mode_o         <= '0;
            au_shift_o        <= '0;
            bincu_threshold_o <= '0;
            filter_mode_o     <= '0;
        end
        else if (commit)
        begin
            tx_start_addr_o   <= tx_start_addr_i;
            tx_datasize_o     <= tx_datasize_i;
            tx_mode_o         <= tx_mode_i;
            tx_len_o          <= tx_len_i;
            rx_start_addr_o   <= rx_start_addr_i;
            rx_datasize_o     <= rx_datasize_i;
            rx_mode_o         <= rx_mode_i;
            rx_len_o          <= rx_len_i;
            au_use_signed_o   <= au_use_signed_i;
            au_bypass_o       <= au_bypass_i;
            au_mode_o         <= au_mode_i;
            au_shift_o        <= au_shift_i;
            bincu_threshold_o <= bincu_threshold_i;
            filter_mode_o     <= filter_mode_i;
        end
    end

    a_start_single: assert property (@(posedge clk_i) disable iff (!rstn_i)
        filter_start_o |=> !filter_start_o);

    // Bank moves only together with the entry into JOB_SAMPLE
    a_bank_on_sample: assert property (@(posedge clk_i) disable iff (!rstn_i)
        $changed({tx_start_addr_o, tx_datasize_o, tx_mode_o, tx_len_o,
                  rx_start_addr_o, rx_datasize_o, rx_mode_o, rx_len_o,
                  au_use_signed_o, au_bypass_o, au_mode_o, au_shift_o,
                  bincu_threshold_o, filter_mode_o})
        |-> (state_q == JOB_SAMPLE));

endmodule

// ==== include/filt_cfg_settings.svh ====
/*
 * Widths, register word indexes and field positions of the filter configuration block.
 * Field macros expand to a bit range and go straight into a part-select.
 */
`ifndef FILT_CFG_SETTINGS_SVH
`define FILT_CFG_SETTINGS_SVH

`define FILT_L2_AWIDTH      15  // Memory start address, in words
`define FILT_TRANS_SIZE     16  // Transfer length

//////////////////////////////////////////////////
// Register word indexes
//////////////////////////////////////////////////
`define FILT_REG_TX0_ADDR   5'd0
`define FILT_REG_TX0_CFG    5'd1
`define FILT_REG_TX0_LEN    5'd2
`define FILT_REG_TX1_ADDR   5'd3
`define FILT_REG_TX1_CFG    5'd4
`define FILT_REG_TX1_LEN    5'd5
`define FILT_REG_RX_ADDR    5'd6
`define FILT_REG_RX_CFG     5'd7
`define FILT_REG_RX_LEN     5'd8
`define FILT_REG_AU_CFG     5'd9
`define FILT_REG_BINCU_TH   5'd10
`define FILT_REG_FILT_MODE  5'd11
`define FILT_REG_FILT_CMD   5'd12

//////////////////////////////////////////////////
// Field positions
//////////////////////////////////////////////////
`define FILT_ADDR_BITS      (`FILT_L2_AWIDTH-1):0
`define FILT_LEN_BITS       (`FILT_TRANS_SIZE-1):0
`define FILT_CH_DSIZE       1:0
`define FILT_CH_MODE        9:8
`define FILT_AU_SIGNED      0
`define FILT_AU_BYPASS      1
`define FILT_AU_MODE        11:8
`define FILT_AU_SHIFT       20:16
`define FILT_MODE_BITS      2:0
`define FILT_CMD_START      0

`endif

// ==== test/tb_clk_gen.sv ====
/*
 * Testbench clock and reset, 40 ns period.
 * Reset is released on a falling edge after three rising edges.
 */
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk_o,
    output logic rstn_o
);

    initial
    begin
        clk_o = 1'b0;
        forever #20 clk_o = ~clk_o;
    end

    initial
    begin
        rstn_o = 1'b0;
        repeat (3) @(posedge clk_o);
        @(negedge clk_o);
        rstn_o = 1'b1;
    end

endmodule

// ==== test/tb_filt_cfg.sv ====
/*
 * Directed tests of the filter configuration block.
 * Inputs change on the falling edge; outputs are sampled away from the rising edge.
 * Expected register contents come from the field layout of each register.
 */
`timescale 1ns/1ps
`include "filt_cfg_settings.svh"

module tb_filt_cfg;

    import filt_cfg_pkg::*;

    logic clk;
    logic rstn;
    cfg_word_t cfg_wdata;
    cfg_addr_t cfg_addr;
    logic cfg_valid;
    logic cfg_rwn;
    cfg_word_t cfg_rdata;
    logic filter_done;
    logic filter_start;

    l2_addr_t   [1:0] tx_start_addr;
    datasize_t  [1:0] tx_datasize;
    xfer_mode_t [1:0] tx_mode;
    trans_len_t [1:0] tx_len;
    l2_addr_t   rx_start_addr;
    datasize_t  rx_datasize;
    xfer_mode_t rx_mode;
    trans_len_t rx_len;
    logic       au_use_signed;
    logic       au_bypass;
    au_mode_t   au_mode;
    au_shift_t  au_shift;
    cfg_word_t  bincu_threshold;
    filt_mode_t filter_mode;

    cfg_word_t stage_model [0:11];   // Expected staging, masked
    cfg_word_t commit_model [0:11];  // Expected committed bank
    int seed = 74679;
    int error_count = 0;
    int pulse_count = 0;

    tb_clk_gen clk0 (.clk_o(clk), .rstn_o(rstn));

    filt_cfg_top dut0 (
        .clk_i(clk), .rstn_i(rstn),
        .cfg_data_i(cfg_wdata), .cfg_addr_i(cfg_addr),
        .cfg_valid_i(cfg_valid), .cfg_rwn_i(cfg_rwn), .cfg_data_o(cfg_rdata),
        .filter_done_i(filter_done), .filter_start_o(filter_start),
        .tx_start_addr_o(tx_start_addr), .tx_datasize_o(tx_datasize),
        .tx_mode_o(tx_mode), .tx_len_o(tx_len),
        .rx_start_addr_o(rx_start_addr), .rx_datasize_o(rx_datasize),
        .rx_mode_o(rx_mode), .rx_len_o(rx_len),
        .au_use_signed_o(au_use_signed), .au_bypass_o(au_bypass),
        .au_mode_o(au_mode), .au_shift_o(au_shift),
        .bincu_threshold_o(bincu_threshold), .filter_mode_o(filter_mode)
    );

    // Start pulses seen so far
    always @(negedge clk)
    begin
        if (rstn && filter_start)
            pulse_count++;
    end

    //////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////
    function automatic cfg_word_t field_mask(input int idx);
        case (idx)
            0, 3, 6: return 32'h0000_7fff;   // Start address
            1, 4, 7: return 32'h0000_0303;   // Size and mode
            2, 5, 8: return 32'h0000_ffff;
            9:       return 32'h001f_0f03;
            10:      return 32'hffff_ffff;
            11:      return 32'h0000_0007;
            default: return 32'h0;
        endcase
    endfunction

    // Committed outputs placed at their register positions
    function automatic cfg_word_t committed_word(input int idx);
        cfg_word_t w;
        w = '0;
        case (idx)
            0: w[14:0] = tx_start_addr[0];
            1: w = {22'b0, tx_mode[0], 6'b0, tx_datasize[0]};
            2: w[15:0] = tx_len[0];
            3: w[14:0] = tx_start_addr[1];
            4: w = {22'b0, tx_mode[1], 6'b0, tx_datasize[1]};
            5: w[15:0] = tx_len[1];
            6: w[14:0] = rx_start_addr;
            7: w = {22'b0, rx_mode, 6'b0, rx_datasize};
            8: w[15:0] = rx_len;
            9: w = {11'b0, au_shift, 4'b0, au_mode, 6'b0, au_bypass, au_use_signed};
            10: w = bincu_threshold;
            11: w[2:0] = filter_mode;
            default: w = '0;
        endcase
        return w;
    endfunction

    task check_word(input string what, input cfg_word_t got, input cfg_word_t exp);
        if (got !== exp)
        begin
            $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
            error_count++;
        end
    endtask

    task check_bit(input string what, input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("CHECK FAILED at %0t: %s is %b, expected %b", $time, what, got, exp);
            error_count++;
        end
    endtask

    task check_committed();
        for (int i = 0; i < 12; i++)
            check_word($sformatf("committed word %0d", i), committed_word(i), commit_model[i]);
    endtask

    task write_reg(input cfg_addr_t addr, input cfg_word_t data);
        @(negedge clk);
        cfg_addr  = addr;
        cfg_wdata = data;
        cfg_rwn   = 1'b0;
        cfg_valid = 1'b1;
        @(negedge clk);
        cfg_valid = 1'b0;
    endtask

    task read_check(input cfg_addr_t addr, input cfg_word_t exp);
        @(negedge clk);
        cfg_addr  = addr;
        cfg_rwn   = 1'b1;
        cfg_valid = 1'b1;
        #10;
        check_word($sformatf("readback of index %0d", addr), cfg_rdata, exp);
        @(negedge clk);
        cfg_valid = 1'b0;
    endtask

    task pulse_done();
        @(negedge clk);
        filter_done = 1'b1;
        @(negedge clk);
        filter_done = 1'b0;
    endtask

    task take_count(output int n);
        @(posedge clk);
        n = pulse_count;
    endtask

    task wait_for_start();
        bit seen;
        seen = 1'b0;
        for (int k = 0; k < 8 && !seen; k++)
        begin
            if (filter_start)
                seen = 1'b1;
            else
                @(negedge clk);
        end
        if (!seen)
        begin
            $display("No filter start pulse within 8 cycles at %0t", $time);
            error_count++;
        end
    endtask

    task stage_random();
        cfg_word_t w;
        for (int i = 0; i < 12; i++)
        begin
            w = $random(seed);
            write_reg(i, w);
            stage_model[i] = w & field_mask(i);
        end
    endtask

    task expect_pulses(input int c0, input int delta, input string what);
        int c1;
        take_count(c1);
        if (c1 - c0 != delta)
        begin
            $display("CHECK FAILED at %0t: %s gave %0d start pulses, expected %0d",
                     $time, what, c1 - c0, delta);
            error_count++;
        end
    endtask

    //////////////////////////////////////////////////
    // Tests
    //////////////////////////////////////////////////
    task test_reset();
        check_bit("filter_start after reset", filter_start, 1'b0);
        check_committed();
        for (int i = 0; i <= 12; i++)
            read_check(i, 32'h0);
    endtask

    task test_readback();
        stage_random();
        for (int i = 0; i < 12; i++)
            read_check(i, stage_model[i]);
        for (int i = 12; i < 32; i++)
            read_check(i, 32'h0);
    endtask

    task test_isolation();
        check_committed();
        check_bit("filter_start without command", filter_start, 1'b0);
    endtask

    task test_start_sequence();
        int c0;
        // Block is idle here, so a wrong start would show
        take_count(c0);
        write_reg(`FILT_REG_FILT_CMD, $random(seed) & ~32'h1);
        repeat (4) @(negedge clk);
        expect_pulses(c0, 0, "command with start bit clear");
        write_reg(`FILT_REG_FILT_CMD, 32'h1);   // Edge N
        check_bit("filter_start at N+0.5", filter_start, 1'b0);
        @(negedge clk);
        check_bit("filter_start at N+1.5", filter_start, 1'b0);
        check_committed();
        @(negedge clk);
        check_bit("filter_start at N+2.5", filter_start, 1'b1);
        commit_model = stage_model;
        check_committed();
        @(negedge clk);
        check_bit("filter_start at N+3.5", filter_start, 1'b0);
    endtask

    task test_busy_pending();
        int c0;
        take_count(c0);
        stage_random();
        write_reg(`FILT_REG_FILT_CMD, 32'h1);
        write_reg(`FILT_REG_FILT_CMD, 32'h1);
        repeat (4) @(negedge clk);
        check_committed();
        expect_pulses(c0, 0, "starts while busy");
        take_count(c0);
        pulse_done();
        wait_for_start();
        commit_model = stage_model;
        check_committed();
        repeat (4) @(negedge clk);
        expect_pulses(c0, 1, "done with pending start");
        take_count(c0);
        pulse_done();
        repeat (4) @(negedge clk);
        expect_pulses(c0, 0, "done without pending start");
        check_committed();
    endtask

    task test_done_idle();
        int c0;
        take_count(c0);
        pulse_done();
        repeat (4) @(negedge clk);
        expect_pulses(c0, 0, "done while idle");
        check_committed();
        stage_random();
        take_count(c0);
        write_reg(`FILT_REG_FILT_CMD, 32'h1);
        wait_for_start();
        commit_model = stage_model;
        check_committed();
        repeat (4) @(negedge clk);
        expect_pulses(c0, 1, "start after idle done");
        pulse_done();
    endtask

    // Tests take a few hundred cycles
    initial
    begin
        #(2000 * 40);
        $display("Timeout: the run did not finish within 2000 clock cycles");
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial
    begin
        cfg_wdata   = '0;
        cfg_addr    = '0;
        cfg_valid   = 1'b0;
        cfg_rwn     = 1'b0;
        filter_done = 1'b0;
        for (int i = 0; i < 12; i++)
        begin
            stage_model[i]  = '0;
            commit_model[i] = '0;
        end
        wait (rstn === 1'b1);
        @(negedge clk);
        test_reset();
        test_readback();
        test_isolation();
        test_start_sequence();
        test_busy_pending();
        test_done_idle();
        repeat (2) @(negedge clk);
        $display("Errors: %0d", error_count);
        if (error_count == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule
